// File: list.f
+incdir+testbench
verilog/crypto_fu_pkg.sv
verilog/crypto_xperm.sv
verilog/crypto_hash_sigma.sv
verilog/crypto_fu_ctrl.sv
verilog/crypto_fu_top.sv
testbench/tb_crypto_fu.sv

// File: testbench/tb_crypto_fu_model.svh
// Reference model for the crypto functional unit testbench
// Expected rd for each opcode, built straight from the lane-index
// rules of xperm4/xperm8 and the rotate-xor rules of SHA-256 and SM3.

`ifndef TB_CRYPTO_FU_MODEL_SVH
`define TB_CRYPTO_FU_MODEL_SVH

// Rotate through a doubled word
function automatic logic [31:0] rot_right(input logic [31:0] x, input int n);
    logic [63:0] dbl;
    dbl = {x, x} >> n;
    return dbl[31:0];
endfunction

function automatic logic [31:0] rot_left(input logic [31:0] x, input int n);
    return rot_right(x, 32 - n);  // Left by n is right by 32-n
endfunction

function automatic logic [31:0] model_xperm4(input logic [31:0] rs1, input logic [31:0] rs2);
    logic [31:0] res;
    logic [3:0]  idx;
    res = '0;
    for (int i = 0; i < 8; i++) begin
        idx = rs2[4*i +: 4];
        if (idx < 4'd8) res[4*i +: 4] = 4'(rs1 >> (4 * idx));  // Index 8..15 gives zero
    end
    return res;
endfunction

function automatic logic [31:0] model_xperm8(input logic [31:0] rs1, input logic [31:0] rs2);
    logic [31:0] res;
    logic [7:0]  idx;
    res = '0;
    for (int i = 0; i < 4; i++) begin
        idx = rs2[8*i +: 8];
        if (idx < 8'd4) res[8*i +: 8] = 8'(rs1 >> (8 * idx));  // Only bytes 0..3 exist
    end
    return res;
endfunction

function automatic logic [31:0] expected_rd(input crypto_fu_pkg::fu_req_t r);
    case (r.op)
        crypto_fu_pkg::op_xperm4:      return model_xperm4(r.rs1, r.rs2);
        crypto_fu_pkg::op_xperm8:      return model_xperm8(r.rs1, r.rs2);
        crypto_fu_pkg::op_sha256_sig0:
            return rot_right(r.rs1, 7) ^ rot_right(r.rs1, 18) ^ (r.rs1 >> 3);
        crypto_fu_pkg::op_sha256_sig1:
            return rot_right(r.rs1, 17) ^ rot_right(r.rs1, 19) ^ (r.rs1 >> 10);
        crypto_fu_pkg::op_sha256_sum0:
            return rot_right(r.rs1, 2) ^ rot_right(r.rs1, 13) ^ rot_right(r.rs1, 22);
        crypto_fu_pkg::op_sha256_sum1:
            return rot_right(r.rs1, 6) ^ rot_right(r.rs1, 11) ^ rot_right(r.rs1, 25);
        crypto_fu_pkg::op_sm3_p0:
            return r.rs1 ^ rot_left(r.rs1, 9) ^ rot_left(r.rs1, 17);
        crypto_fu_pkg::op_sm3_p1:
            return r.rs1 ^ rot_left(r.rs1, 15) ^ rot_left(r.rs1, 23);
        default:                       return '0;
    endcase
endfunction

function automatic string op_name(input crypto_fu_pkg::crypto_op_t op);
    return op.name();  // Test name in error lines
endfunction

`endif

// File: testbench/tb_crypto_fu.sv
// Crypto functional unit testbench
// Drives directed and random requests through the valid/ready port,
// one at a time, and checks results and handshake timing with
// concurrent assertions against the reference model.

`timescale 1ns/1ns
`default_nettype none

module tb_crypto_fu;

    `include "tb_crypto_fu_model.svh"

    // --------------------------------------------------
    // Run length and limits
    // --------------------------------------------------
    localparam int clk_period_ns = 40;
    localparam int reset_cycles  = 3;
    localparam int n_random      = 200;   // Random requests
    localparam int n_directed    = 18;    // Edge-case requests
    localparam int margin_cycles = 50;
    localparam int timeout_ns    = (reset_cycles + 3 * (n_random + n_directed) + margin_cycles)
                                   * clk_period_ns;  // 3 cycles per request

    logic                           dut_g_clk;
    logic                           dut_g_resetn;
    logic                           valid;
    crypto_fu_pkg::fu_req_t         req;
    logic                           ready;
    logic [crypto_fu_pkg::xlen-1:0] rd;
    logic                           seen_valid;   // First request issued
    int                             issue_count;  // Requests sent
    int                             ready_count;  // Ready pulses seen

    crypto_fu_top i_crypto_fu_top (
        .dut_g_clk    (dut_g_clk),
        .dut_g_resetn (dut_g_resetn),
        .valid        (valid),
        .req          (req),
        .ready        (ready),
        .rd           (rd)
    );

    always #(clk_period_ns / 2) dut_g_clk = ~dut_g_clk;

    always @(posedge dut_g_clk) begin
        if (!dut_g_resetn && ready) ready_count <= ready_count + 1;  // One per pulse
    end

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "Stopping at first error");
    endtask

    // --------------------------------------------------
    // Checking assertions
    // --------------------------------------------------
    a_reset_quiet : assert property (@(posedge dut_g_clk) disable iff (dut_g_resetn)
        !seen_valid |-> (!ready && rd == '0))
        else report_fail($sformatf("FAIL reset_idle expected %s actual ready=%0b rd=%h",
                                   "ready=0 rd=00000000", $sampled(ready), $sampled(rd)));

    a_result : assert property (@(posedge dut_g_clk) disable iff (dut_g_resetn)
        ready |-> (rd == expected_rd(req)))
        else report_fail($sformatf("FAIL %s expected %h actual %h", op_name($sampled(req.op)),
                                   expected_rd($sampled(req)), $sampled(rd)));

    a_ready_latency : assert property (@(posedge dut_g_clk) disable iff (dut_g_resetn)
        $rose(valid) |=> ready)
        else report_fail("ready did not rise one cycle after valid was raised");

    a_ready_single : assert property (@(posedge dut_g_clk) disable iff (dut_g_resetn)
        ready |=> !ready)
        else report_fail("ready stayed high for more than one cycle");

    a_ready_with_valid : assert property (@(posedge dut_g_clk) disable iff (dut_g_resetn)
        ready |-> valid)
        else report_fail("ready came high with no request waiting");

    // Hold request until ready, then one idle cycle
    task automatic issue_request(input crypto_fu_pkg::crypto_op_t op,
                                 input logic [31:0] rs1, input logic [31:0] rs2);
        @(negedge dut_g_clk);
        valid       = 1'b1;
        req.op      = op;
        req.rs1     = rs1;
        req.rs2     = rs2;
        seen_valid  = 1'b1;
        issue_count = issue_count + 1;
        do @(negedge dut_g_clk); while (!ready);
        @(negedge dut_g_clk);  // Transfer done at the edge before this
        valid = 1'b0;
    endtask

    initial begin
        #(timeout_ns);
        report_fail("Timeout: the run did not finish within its time limit");
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin
        crypto_fu_pkg::crypto_op_t op;
        logic [31:0]               rs1;
        logic [31:0]               rs2;
        void'($urandom(32'h5da7_43d2));
        dut_g_clk    = 1'b0;
        dut_g_resetn = 1'b1;  // Held in reset
        valid        = 1'b0;
        req          = '0;
        seen_valid   = 1'b0;
        issue_count  = 0;
        ready_count  = 0;
        repeat (reset_cycles) @(negedge dut_g_clk);
        dut_g_resetn = 1'b0;
        repeat (2) @(negedge dut_g_clk);  // Idle outputs under check

        // Crossbar edge cases
        issue_request(crypto_fu_pkg::op_xperm4, 32'h89ab_cdef, 32'h7654_3210);  // Identity
        issue_request(crypto_fu_pkg::op_xperm4, 32'h89ab_cdef, 32'hfedc_ba98);  // All out of range
        issue_request(crypto_fu_pkg::op_xperm4, 32'h89ab_cdef, 32'h0f1e_2d3c);  // Mixed
        issue_request(crypto_fu_pkg::op_xperm8, 32'hdead_beef, 32'h0001_0203);  // Byte reverse
        issue_request(crypto_fu_pkg::op_xperm8, 32'hdead_beef, 32'h04ff_8005);  // All zero lanes
        issue_request(crypto_fu_pkg::op_xperm8, 32'hdead_beef, 32'h0304_0209);  // Mixed

        // Hash ops on extreme words
        for (int k = 2; k < 8; k++) begin
            issue_request(crypto_fu_pkg::crypto_op_t'(k), 32'hffff_ffff, 32'h0);
            issue_request(crypto_fu_pkg::crypto_op_t'(k), 32'h8000_0001, $urandom);
        end

        for (int n = 0; n < n_random; n++) begin
            op  = crypto_fu_pkg::crypto_op_t'($urandom_range(7, 0));
            rs1 = $urandom;
            rs2 = $urandom;
            if (op == crypto_fu_pkg::op_xperm8 && $urandom_range(1, 0) == 1)
                rs2 = rs2 & 32'h0707_0707;  // More in-range byte indices
            if (op == crypto_fu_pkg::op_xperm4 && $urandom_range(1, 0) == 1)
                rs2 = rs2 & 32'h7777_7777;  // All nibble indices legal
            issue_request(op, rs1, rs2);
        end

        if (ready_count != issue_count) begin
            report_fail($sformatf("FAIL ready_pulses expected %0d actual %0d",
                                  issue_count, ready_count));
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verilog/crypto_fu_top.sv
// Crypto functional unit top level
// Takes one RV32 request at a time under valid/ready and returns one
// result a fixed cycle later. The crossbar and hash units evaluate the
// held request in parallel and the control block registers the one
// the opcode addresses.

`timescale 1ns/1ns
`default_nettype none

module crypto_fu_top (
    input  wire                                dut_g_clk,     // Unit clock
    input  wire                                dut_g_resetn,  // Sync reset, active high
    input  wire                                valid,         // Request valid
    input  var crypto_fu_pkg::fu_req_t         req,           // Opcode, rs1, rs2
    output logic                               ready,         // Result valid
    output logic [crypto_fu_pkg::xlen-1:0]     rd             // Result
);

    // --------------------------------------------------
    // Datapath results
    // --------------------------------------------------
    logic [crypto_fu_pkg::xlen-1:0] xperm_rd;  // From crossbar unit
    logic [crypto_fu_pkg::xlen-1:0] hash_rd;   // From hash unit

    crypto_xperm i_crypto_xperm (
        .req      (req),
        .xperm_rd (xperm_rd)
    );

    crypto_hash_sigma i_crypto_hash_sigma (
        .req      (req),
        .hash_rd  (hash_rd)
    );

    // --------------------------------------------------
    // Handshake and result register
    // --------------------------------------------------
    crypto_fu_ctrl i_crypto_fu_ctrl (
        .dut_g_clk    (dut_g_clk),
        .dut_g_resetn (dut_g_resetn),
        .valid        (valid),
        .op           (req.op),     // Only the opcode steers control
        .xperm_rd     (xperm_rd),
        .hash_rd      (hash_rd),
        .ready        (ready),
        .rd           (rd)
    );

endmodule

`default_nettype wire

// File: verilog/crypto_fu_ctrl.sv
// Crypto functional unit control
// Two-state handshake FSM. On a valid request in idle it captures the
// result of the addressed datapath into rd and raises ready for one
// cycle, then returns to idle. Also checks the requester side rules.

`timescale 1ns/1ns
`default_nettype none

module crypto_fu_ctrl (
    input  wire                                dut_g_clk,     // Unit clock
    input  wire                                dut_g_resetn,  // Sync reset, active high
    input  wire                                valid,         // Request valid
    input  var crypto_fu_pkg::crypto_op_t      op,            // Request opcode
    input  wire  [crypto_fu_pkg::xlen-1:0]     xperm_rd,      // Crossbar result
    input  wire  [crypto_fu_pkg::xlen-1:0]     hash_rd,       // Hash result
    output logic                               ready,         // Result valid, one cycle
    output logic [crypto_fu_pkg::xlen-1:0]     rd             // Registered result
);

    // --------------------------------------------------
    // State
    // --------------------------------------------------
    crypto_fu_pkg::fu_state_t       state;       // Current state
    crypto_fu_pkg::fu_state_t       state_nxt;   // Next state
    logic                           accept;      // Request taken this edge
    logic [crypto_fu_pkg::xlen-1:0] sel_rd;      // Result to capture

    // Take a request only from idle
    assign accept = valid && (state == crypto_fu_pkg::st_idle);

    // Opcode class picks the datapath
    assign sel_rd = crypto_fu_pkg::op_is_xperm(op) ? xperm_rd : hash_rd;

    always_comb begin
        state_nxt = state;
        case (state)
            crypto_fu_pkg::st_idle: begin
                if (valid) begin
                    state_nxt = crypto_fu_pkg::st_done;  // Latch result now
                end
            end
            crypto_fu_pkg::st_done: begin
                state_nxt = crypto_fu_pkg::st_idle;      // Always one cycle
            end
            default: begin
                state_nxt = crypto_fu_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge dut_g_clk) begin
        if (dut_g_resetn) begin
            state <= crypto_fu_pkg::st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // --------------------------------------------------
    // Result register
    // --------------------------------------------------
    always_ff @(posedge dut_g_clk) begin
        if (dut_g_resetn) begin
            rd <= '0;              // Zero out of reset
        end else if (accept) begin
            rd <= sel_rd;          // Held until the next accept
        end
    end

    // Ready is the done state itself
    assign ready = (state == crypto_fu_pkg::st_done);

    // --------------------------------------------------
    // Assertions
    // --------------------------------------------------
    // Requester must only present defined opcodes
    a_op_legal : assert property (
        @(posedge dut_g_clk) disable iff (dut_g_resetn)
        valid |-> crypto_fu_pkg::op_is_legal(op)
    ) else $error("illegal opcode %0d with valid", op);

    // One ready pulse per request, never back to back
    a_ready_pulse : assert property (
        @(posedge dut_g_clk) disable iff (dut_g_resetn)
        ready |=> !ready
    ) else $error("ready held for two cycles");

    // Opcode must not change while the request waits
    a_op_stable : assert property (
        @(posedge dut_g_clk) disable iff (dut_g_resetn)
        (valid && !ready) |=> $stable(op)
    ) else $error("opcode changed before ready");

endmodule

`default_nettype wire

// File: verilog/crypto_hash_sigma.sv
// Hash rotate-xor unit
// SHA-256 sigma0/sigma1/sum0/sum1 and SM3 P0/P1 on rs1.
// All six results are formed in parallel from fixed rotates and
// shifts, then the opcode picks one. Purely combinational.

`timescale 1ns/1ns
`default_nettype none

module crypto_hash_sigma (
    input  var crypto_fu_pkg::fu_req_t         req,     // Opcode and sources
    output logic [crypto_fu_pkg::xlen-1:0]     hash_rd  // Hash function result
);

    // --------------------------------------------------
    // Rotate helpers
    // --------------------------------------------------
    // Constant amounts only, so these are just wiring
    function automatic logic [crypto_fu_pkg::xlen-1:0] ror(
        input logic [crypto_fu_pkg::xlen-1:0] x,
        input int                             n
    );
        return (x >> n) | (x << (crypto_fu_pkg::xlen - n));
    endfunction

    function automatic logic [crypto_fu_pkg::xlen-1:0] rol(
        input logic [crypto_fu_pkg::xlen-1:0] x,
        input int                             n
    );
        return (x << n) | (x >> (crypto_fu_pkg::xlen - n));
    endfunction

    // --------------------------------------------------
    // Function outputs
    // --------------------------------------------------
    logic [crypto_fu_pkg::xlen-1:0] x;         // rs1, the only operand
    logic [crypto_fu_pkg::xlen-1:0] sha_sig0;  // SHA-256 small sigma 0
    logic [crypto_fu_pkg::xlen-1:0] sha_sig1;  // SHA-256 small sigma 1
    logic [crypto_fu_pkg::xlen-1:0] sha_sum0;  // SHA-256 big sigma 0
    logic [crypto_fu_pkg::xlen-1:0] sha_sum1;  // SHA-256 big sigma 1
    logic [crypto_fu_pkg::xlen-1:0] sm3_p0;    // SM3 P0
    logic [crypto_fu_pkg::xlen-1:0] sm3_p1;    // SM3 P1

    assign x = req.rs1;

    // Small sigmas mix in a plain shift
    assign sha_sig0 = ror(x, 7)  ^ ror(x, 18) ^ (x >> 3);
    assign sha_sig1 = ror(x, 17) ^ ror(x, 19) ^ (x >> 10);

    // Big sigmas are three rotates
    assign sha_sum0 = ror(x, 2)  ^ ror(x, 13) ^ ror(x, 22);
    assign sha_sum1 = ror(x, 6)  ^ ror(x, 11) ^ ror(x, 25);

    // SM3 permutations keep x itself
    assign sm3_p0   = x ^ rol(x, 9)  ^ rol(x, 17);
    assign sm3_p1   = x ^ rol(x, 15) ^ rol(x, 23);

    // --------------------------------------------------
    // Result select
    // --------------------------------------------------
    always_comb begin
        case (req.op)
            crypto_fu_pkg::op_sha256_sig0: hash_rd = sha_sig0;
            crypto_fu_pkg::op_sha256_sig1: hash_rd = sha_sig1;
            crypto_fu_pkg::op_sha256_sum0: hash_rd = sha_sum0;
            crypto_fu_pkg::op_sha256_sum1: hash_rd = sha_sum1;
            crypto_fu_pkg::op_sm3_p0:      hash_rd = sm3_p0;   // Compression P0
            crypto_fu_pkg::op_sm3_p1:      hash_rd = sm3_p1;   // Expansion P1
            default:                       hash_rd = '0;       // xperm ops
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/crypto_xperm.sv
// Crossbar permutation unit
// Builds xperm4 and xperm8 results. Each lane of rs2 picks a lane of
// rs1 by index; an index past the last lane yields a zero lane.
// Purely combinational.

`timescale 1ns/1ns
`default_nettype none

module crypto_xperm (
    input  var crypto_fu_pkg::fu_req_t         req,      // Opcode and sources
    output logic [crypto_fu_pkg::xlen-1:0]     xperm_rd  // Permuted result
);

    // --------------------------------------------------
    // Operand unpack
    // --------------------------------------------------
    logic [crypto_fu_pkg::xlen-1:0] rs1;        // Table of lanes
    logic [crypto_fu_pkg::xlen-1:0] rs2;        // Lane indices
    logic [crypto_fu_pkg::xlen-1:0] xperm4_rd;  // Nibble permute result
    logic [crypto_fu_pkg::xlen-1:0] xperm8_rd;  // Byte permute result

    assign rs1 = req.rs1;
    assign rs2 = req.rs2;

    // --------------------------------------------------
    // Nibble crossbar
    // --------------------------------------------------
    always_comb begin : p_xperm4
        logic [crypto_fu_pkg::nibble_w-1:0]  idx;  // Index from rs2
        logic [crypto_fu_pkg::nib_idx_w-1:0] sel;  // In-range part of idx
        xperm4_rd = '0;
        for (int i = 0; i < crypto_fu_pkg::xlen_nibbles; i++) begin
            idx = rs2[i*crypto_fu_pkg::nibble_w +: crypto_fu_pkg::nibble_w];
            sel = idx[crypto_fu_pkg::nib_idx_w-1:0];
            // Index 8 and up leaves the lane at zero
            if (idx < crypto_fu_pkg::xlen_nibbles) begin
                xperm4_rd[i*crypto_fu_pkg::nibble_w +: crypto_fu_pkg::nibble_w] =
                    rs1[sel*crypto_fu_pkg::nibble_w +: crypto_fu_pkg::nibble_w];
            end
        end
    end

    // --------------------------------------------------
    // Byte crossbar
    // --------------------------------------------------
    always_comb begin : p_xperm8
        logic [crypto_fu_pkg::byte_w-1:0]     idx;  // Index from rs2
        logic [crypto_fu_pkg::byte_idx_w-1:0] sel;  // In-range part of idx
        xperm8_rd = '0;
        for (int i = 0; i < crypto_fu_pkg::xlen_bytes; i++) begin
            idx = rs2[i*crypto_fu_pkg::byte_w +: crypto_fu_pkg::byte_w];
            sel = idx[crypto_fu_pkg::byte_idx_w-1:0];
            // Only indices 0..3 name a real byte
            if (idx < crypto_fu_pkg::xlen_bytes) begin
                xperm8_rd[i*crypto_fu_pkg::byte_w +: crypto_fu_pkg::byte_w] =
                    rs1[sel*crypto_fu_pkg::byte_w +: crypto_fu_pkg::byte_w];
            end
        end
    end

    // --------------------------------------------------
    // Result select
    // --------------------------------------------------
    always_comb begin
        case (req.op)
            crypto_fu_pkg::op_xperm4: xperm_rd = xperm4_rd;  // Nibble lanes
            crypto_fu_pkg::op_xperm8: xperm_rd = xperm8_rd;  // Byte lanes
            default:                  xperm_rd = '0;         // Hash ops, unused here
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/crypto_fu_pkg.sv
// Crypto functional unit package
// Shared widths, the opcode and state encodings, the request bundle
// and small helpers that sort opcodes into their datapath class.
// Covers xperm4/xperm8, SHA-256 sigma/sum and SM3 p0/p1 on RV32.

`default_nettype none

package crypto_fu_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    localparam int xlen         = 32;               // Data width, RV32 only
    localparam int nibble_w     = 4;                // xperm4 lane width
    localparam int byte_w       = 8;                // xperm8 lane width
    localparam int op_w         = 4;                // Opcode field width

    localparam int xlen_nibbles = xlen / nibble_w;  // 8 nibble lanes
    localparam int xlen_bytes   = xlen / byte_w;    // 4 byte lanes
    localparam int nib_idx_w    = $clog2(xlen_nibbles); // Legal nibble index bits
    localparam int byte_idx_w   = $clog2(xlen_bytes);   // Legal byte index bits

    // --------------------------------------------------
    // Opcodes
    // --------------------------------------------------
    // Encodings 8..15 are illegal
    typedef enum logic [op_w-1:0] {
        op_xperm4      = 4'd0,  // Crossbar permute, nibbles
        op_xperm8      = 4'd1,  // Crossbar permute, bytes
        op_sha256_sig0 = 4'd2,  // SHA-256 sigma 0
        op_sha256_sig1 = 4'd3,  // SHA-256 sigma 1
        op_sha256_sum0 = 4'd4,  // SHA-256 sum 0
        op_sha256_sum1 = 4'd5,  // SHA-256 sum 1
        op_sm3_p0      = 4'd6,  // SM3 permutation P0
        op_sm3_p1      = 4'd7   // SM3 permutation P1
    } crypto_op_t;

    // One request, held stable until ready
    typedef struct packed {
        crypto_op_t        op;   // Operation
        logic [xlen-1:0]   rs1;  // Source register 1
        logic [xlen-1:0]   rs2;  // Source register 2
    } fu_req_t;                  // 68 bits

    // Control FSM states
    typedef enum logic {
        st_idle = 1'b0,  // Waiting for valid
        st_done = 1'b1   // Result out, ready high
    } fu_state_t;

    // --------------------------------------------------
    // Opcode class helpers
    // --------------------------------------------------
    // Crossbar class, everything else legal is hash class
    function automatic logic op_is_xperm(input crypto_op_t op);
        return (op == op_xperm4) || (op == op_xperm8);
    endfunction

    // True for the eight defined encodings only
    function automatic logic op_is_legal(input crypto_op_t op);
        return op inside {op_xperm4, op_xperm8,
                          op_sha256_sig0, op_sha256_sig1,
                          op_sha256_sum0, op_sha256_sum1,
                          op_sm3_p0, op_sm3_p1};
    endfunction

endpackage

`default_nettype wire
